// ==== common/piano_consts.svh ====
`ifndef PIANO_CONSTS_SVH
`define PIANO_CONSTS_SVH

// game geometry
`define PIANO_LANES 4
`define PIANO_DEPTH 16

// timing periods in clock cycles, small for simulation
// a board build scales these up
`define PIANO_KEY_PERIOD 8
`define PIANO_SCROLL_PERIOD 64
`define PIANO_SPAWN_PERIOD 96
`define PIANO_ROW_PERIOD 4

// lane picker
`define PIANO_LFSR_SEED 16'hfeac

// two decimal digits
`define PIANO_SCORE_MAX 99

`endif

// ==== common/piano_pkg.sv ====
`include "piano_consts.svh"

package piano_pkg;

  typedef logic [`PIANO_DEPTH-1:0] lane_bits_t;  // bit 0 is the bottom pixel
  typedef logic [$clog2(`PIANO_LANES)-1:0] lane_idx_t;
  typedef logic [3:0] key_row_t;                 // one-cold
  typedef logic [6:0] score_t;
  typedef logic [3:0] bcd_t;
  typedef logic [6:0] seg_t;                     // active low, gfedcba
  typedef logic [7:0] mat_row_t;                 // one-cold

  typedef struct packed {
    seg_t tens;
    seg_t units;
  } seg_pair_t;

  typedef struct packed {
    lane_bits_t bits;
    logic       hit;
  } lane_out_t;

  typedef enum logic [1:0] {
    SP_IDLE,
    SP_REQ,
    SP_RELEASE
  } spawn_state_t;

endpackage

// ==== rtl/tile_spawner.sv ====
`timescale 1ns/1ns
`include "piano_consts.svh"

module tile_spawner (
  input  logic                    clk,
  input  logic                    rst,
  input  logic [`PIANO_LANES-1:0] spawn_ack,
  output logic [`PIANO_LANES-1:0] spawn_req,
  output logic                    scroll_tick
);
  import piano_pkg::*;

  localparam int SCROLL_W = $clog2(`PIANO_SCROLL_PERIOD);
  localparam int SPAWN_W = $clog2(`PIANO_SPAWN_PERIOD);

  logic [15:0]         lfsr;
  logic [SCROLL_W-1:0] scroll_cnt;
  logic [SPAWN_W-1:0]  spawn_cnt;
  logic                spawn_tick;
  lane_idx_t           sel;
  spawn_state_t        state;

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      lfsr <= `PIANO_LFSR_SEED;
    end else begin
      lfsr <= {lfsr[14:0], lfsr[15] ^ lfsr[0]};
    end
  end

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      scroll_cnt  <= '0;
      scroll_tick <= 1'b0;
      spawn_cnt   <= '0;
      spawn_tick  <= 1'b0;
    end else begin
      scroll_tick <= (scroll_cnt == SCROLL_W'(`PIANO_SCROLL_PERIOD - 1));
      spawn_tick  <= (spawn_cnt == SPAWN_W'(`PIANO_SPAWN_PERIOD - 1));
      if (scroll_cnt == SCROLL_W'(`PIANO_SCROLL_PERIOD - 1)) scroll_cnt <= '0;
      else scroll_cnt <= scroll_cnt + 1'b1;
      if (spawn_cnt == SPAWN_W'(`PIANO_SPAWN_PERIOD - 1)) spawn_cnt <= '0;
      else spawn_cnt <= spawn_cnt + 1'b1;
    end
  end

  // four-phase handshake with the chosen lane
  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      state     <= SP_IDLE;
      sel       <= '0;
      spawn_req <= '0;
    end else begin
      case (state)
        SP_IDLE: begin
          if (spawn_tick) begin  // ticks during a handshake are dropped
            sel                                  <= lfsr[$bits(lane_idx_t)-1:0];
            spawn_req[lfsr[$bits(lane_idx_t)-1:0]] <= 1'b1;
            state                                <= SP_REQ;
          end
        end
        SP_REQ: begin
          if (spawn_ack[sel]) begin
            spawn_req <= '0;
            state     <= SP_RELEASE;
          end
        end
        SP_RELEASE: begin
          if (!spawn_ack[sel]) state <= SP_IDLE;
        end
        default: state <= SP_IDLE;
      endcase
    end
  end

endmodule

// ==== lane/tile_lane.sv ====
`timescale 1ns/1ns
`include "piano_consts.svh"

module tile_lane (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 scroll_tick,
  input  logic                 spawn_req,
  input  logic                 press,
  output logic                 spawn_ack,
  output piano_pkg::lane_out_t lane
);
  import piano_pkg::*;

  localparam lane_bits_t TILE = {2'b11, {(`PIANO_DEPTH - 2){1'b0}}};

  lane_bits_t col;
  lane_bits_t col_cleared;
  logic       hit_q;
  logic       take;

  // a hit removes the bottom tile before any shift
  always_comb begin
    col_cleared = col;
    if (press && col[0]) begin
      col_cleared[1:0] = 2'b00;
    end
  end

  // top two pixels must be dark so tiles keep a gap between them
  assign take = scroll_tick && spawn_req && !spawn_ack &&
                (col[`PIANO_DEPTH-1 -: 2] == 2'b00);

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      col       <= '0;
      hit_q     <= 1'b0;
      spawn_ack <= 1'b0;
    end else begin
      hit_q <= press && col[0];
      if (scroll_tick) begin
        if (take) col <= (col_cleared >> 1) | TILE;
        else col <= col_cleared >> 1;
      end else begin
        col <= col_cleared;
      end
      if (take) begin
        spawn_ack <= 1'b1;
      end else if (!spawn_req) begin
        spawn_ack <= 1'b0;  // request withdrawn
      end
    end
  end

  assign lane.bits = col;
  assign lane.hit  = hit_q;

endmodule

// ==== rtl/keypad_scan.sv ====
`timescale 1ns/1ns
`include "piano_consts.svh"

module keypad_scan (
  input  logic                    clk,
  input  logic                    rst,
  input  logic [3:0]              keypad_col,  // keys sit on column 0
  output piano_pkg::key_row_t     keypad_row,
  output logic [`PIANO_LANES-1:0] press
);

  localparam int CNT_W = $clog2(`PIANO_KEY_PERIOD);

  logic [CNT_W-1:0] cnt;
  logic             row_end;

  assign row_end = (cnt == CNT_W'(`PIANO_KEY_PERIOD - 1));

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      cnt        <= '0;
      keypad_row <= 4'b1110;
    end else if (row_end) begin
      cnt        <= '0;
      keypad_row <= {keypad_row[2:0], keypad_row[3]};  // 1110 -> 1101 -> 1011 -> 0111
    end else begin
      cnt <= cnt + 1'b1;
    end
  end

  // row 1110 belongs to lane 3, row 0111 to lane 0
  always_comb begin
    for (int i = 0; i < `PIANO_LANES; i++) begin
      press[i] = row_end && !keypad_col[0] && !keypad_row[3 - i];
    end
  end

endmodule

// ==== rtl/score_display.sv ====
`timescale 1ns/1ns
`include "piano_consts.svh"

module score_display (
  input  logic                    clk,
  input  logic                    rst,
  input  logic [`PIANO_LANES-1:0] hit,
  output piano_pkg::seg_pair_t    digits
);
  import piano_pkg::*;

  score_t score;
  bcd_t   tens;
  bcd_t   units;

  function automatic seg_t seg_of(input bcd_t d);
    case (d)
      4'd0:    seg_of = 7'b1000000;
      4'd1:    seg_of = 7'b1111001;
      4'd2:    seg_of = 7'b0100100;
      4'd3:    seg_of = 7'b0110000;
      4'd4:    seg_of = 7'b0011001;
      4'd5:    seg_of = 7'b0010010;
      4'd6:    seg_of = 7'b0000010;
      4'd7:    seg_of = 7'b1111000;
      4'd8:    seg_of = 7'b0000000;
      4'd9:    seg_of = 7'b0010000;
      default: seg_of = 7'b1111111;  // blank
    endcase
  endfunction

  // one lane hits per cycle at most
  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      score <= '0;
    end else if (|hit && score < score_t'(`PIANO_SCORE_MAX)) begin
      score <= score + 1'b1;
    end
  end

  always_comb begin
    tens = '0;
    for (int k = 1; k <= 9; k++) begin
      if (score >= score_t'(10 * k)) begin
        tens = bcd_t'(k);
      end
    end
    units = bcd_t'(score - score_t'(10 * tens));
  end

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      digits.tens  <= seg_of(bcd_t'(0));
      digits.units <= seg_of(bcd_t'(0));
    end else begin
      digits.tens  <= seg_of(tens);
      digits.units <= seg_of(units);
    end
  end

endmodule

// ==== rtl/dot_matrix_scan.sv ====
`timescale 1ns/1ns
`include "piano_consts.svh"

module dot_matrix_scan (
  input  logic                                    clk,
  input  logic                                    rst,
  input  piano_pkg::lane_bits_t [`PIANO_LANES-1:0] lanes,
  output piano_pkg::mat_row_t                     dot_row,
  output piano_pkg::lane_bits_t                   dot_col
);

  localparam int CNT_W = $clog2(`PIANO_ROW_PERIOD);

  logic [CNT_W-1:0] cnt;
  logic [2:0]       row_idx;

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      cnt     <= '0;
      row_idx <= '0;
      dot_row <= '1;  // no row driven
      dot_col <= '0;
    end else if (cnt == CNT_W'(`PIANO_ROW_PERIOD - 1)) begin
      cnt     <= '0;
      row_idx <= row_idx + 1'b1;
      dot_row <= ~(8'b1000_0000 >> row_idx);  // row r pulls bit 7-r low
      dot_col <= lanes[row_idx[2:1]];         // two rows per lane
    end else begin
      cnt <= cnt + 1'b1;
    end
  end

endmodule

// ==== rtl/piano_top.sv ====
`timescale 1ns/1ns
`include "piano_consts.svh"

module piano_top (
  input  logic                  clk,
  input  logic                  rst,
  input  logic [3:0]            keypad_col,
  output piano_pkg::key_row_t   keypad_row,
  output piano_pkg::mat_row_t   dot_row,
  output piano_pkg::lane_bits_t dot_col,
  output piano_pkg::seg_t       seg_units,
  output piano_pkg::seg_t       seg_tens
);
  import piano_pkg::*;

  logic [`PIANO_LANES-1:0]       spawn_req;
  logic [`PIANO_LANES-1:0]       spawn_ack;
  logic [`PIANO_LANES-1:0]       press;
  logic [`PIANO_LANES-1:0]       hit;
  logic                          scroll_tick;
  lane_bits_t [`PIANO_LANES-1:0] lane_bits;
  seg_pair_t                     digits;

  tile_spawner u_spawner (
    .clk         (clk),
    .rst         (rst),
    .spawn_ack   (spawn_ack),
    .spawn_req   (spawn_req),
    .scroll_tick (scroll_tick)
  );

  generate
    for (genvar i = 0; i < `PIANO_LANES; i++) begin : g_lane
      lane_out_t lane_o;

      tile_lane u_lane (
        .clk         (clk),
        .rst         (rst),
        .scroll_tick (scroll_tick),
        .spawn_req   (spawn_req[i]),
        .press       (press[i]),
        .spawn_ack   (spawn_ack[i]),
        .lane        (lane_o)
      );

      assign lane_bits[i] = lane_o.bits;
      assign hit[i]       = lane_o.hit;
    end
  endgenerate

  keypad_scan u_keypad (
    .clk        (clk),
    .rst        (rst),
    .keypad_col (keypad_col),
    .keypad_row (keypad_row),
    .press      (press)
  );

  score_display u_score (
    .clk    (clk),
    .rst    (rst),
    .hit    (hit),
    .digits (digits)
  );

  dot_matrix_scan u_matrix (
    .clk     (clk),
    .rst     (rst),
    .lanes   (lane_bits),
    .dot_row (dot_row),
    .dot_col (dot_col)
  );

  assign seg_units = digits.units;
  assign seg_tens  = digits.tens;

endmodule

// ==== tb/piano_chk.sv ====
`timescale 1ns/1ns
`include "piano_consts.svh"

module piano_chk (
  input logic                    clk,
  input logic                    rst,
  input logic [`PIANO_LANES-1:0] spawn_req,
  input logic [`PIANO_LANES-1:0] spawn_ack
);

  // ack only falls once its req is gone
  a_ack_release: assert property (@(posedge clk) disable iff (!rst)
    ((~spawn_ack & $past(spawn_ack) & $past(spawn_req)) == '0))
    else $error("spawn_ack dropped while its request was still up");

  // req stays put until the lane answers
  a_req_hold: assert property (@(posedge clk) disable iff (!rst)
    ((spawn_req != '0) && ((spawn_req & spawn_ack) == '0)) |=> (spawn_req == $past(spawn_req)))
    else $error("spawn_req changed before its ack");

  // an ack only rises on a lane that was asked
  a_ack_needs_req: assert property (@(posedge clk) disable iff (!rst)
    ((spawn_ack & ~$past(spawn_ack) & ~$past(spawn_req)) == '0))
    else $error("spawn_ack rose without a request");

  // req drops once ack is seen
  a_req_release: assert property (@(posedge clk) disable iff (!rst)
    ((spawn_req & spawn_ack) != '0) |=> ((spawn_req & $past(spawn_req)) == '0))
    else $error("spawn_req held after ack");

endmodule

bind tile_spawner piano_chk u_chk (
  .clk       (clk),
  .rst       (rst),
  .spawn_req (spawn_req),
  .spawn_ack (spawn_ack)
);

// ==== tb/piano_monitor.sv ====
`timescale 1ns/1ns
`include "piano_consts.svh"

module piano_monitor (
  input  logic                  clk,
  input  logic                  rst,
  input  piano_pkg::key_row_t   keypad_row,
  input  piano_pkg::mat_row_t   dot_row,
  input  piano_pkg::lane_bits_t dot_col,
  input  piano_pkg::seg_t       seg_units,
  input  piano_pkg::seg_t       seg_tens,
  input  logic [69:0]           seg_table,
  input  int                    first_start,
  input  int                    expected_score,
  input  logic                  final_check,
  output int                    error_count
);
  import piano_pkg::*;

  int         cycle;
  int         row_hold;
  int         mat_hold;
  int         mat_idx;
  int         prev_score;
  int         score_now;
  int         tens_d;
  int         units_d;
  logic       started;
  logic       pair_shift;
  key_row_t   prev_row;
  mat_row_t   prev_dot;
  mat_row_t   exp_dot;
  lane_bits_t pair_col;

  function automatic int decode_digit(input seg_t s);
    int d;
    d = -1;
    for (int k = 0; k < 10; k++) begin
      if (seg_table[k*7 +: 7] == s) d = k;
    end
    return d;
  endfunction

  // lit runs come in pairs, a lone pixel only at the bottom
  function automatic logic runs_ok(input lane_bits_t bits);
    int   len;
    logic ok;
    ok = 1'b1;
    len = 0;
    for (int b = 0; b <= `PIANO_DEPTH; b++) begin
      if (b < `PIANO_DEPTH && bits[b]) begin
        len++;
      end else begin
        if ((len % 2 == 1) && (b - len != 0)) ok = 1'b0;
        len = 0;
      end
    end
    return ok;
  endfunction

  task automatic report_value(input string name, input int exp_v, input int act_v);
    error_count++;
    $display("error %0t %s expected %0h actual %0h", $time, name, exp_v, act_v);
  endtask

  task automatic report_text(input string msg);
    error_count++;
    $display("error %0t %s", $time, msg);
  endtask

  initial begin
    error_count = 0;
    cycle = 0;
    started = 1'b0;
    prev_score = 0;
  end

  always @(posedge clk) begin
    if (rst) cycle <= cycle + 1;
  end

  always @(negedge clk) begin
    if (!rst) begin
      started = 1'b0;
    end else if (!started) begin
      started = 1'b1;
      if (keypad_row != 4'b1110) report_value("keypad_row", 4'b1110, keypad_row);
      if (dot_row != 8'hff) report_value("dot_row", 8'hff, dot_row);
      if (dot_col != '0) report_value("dot_col", 0, dot_col);
      if (seg_tens != seg_table[6:0]) report_value("seg_tens", seg_table[6:0], seg_tens);
      if (seg_units != seg_table[6:0]) report_value("seg_units", seg_table[6:0], seg_units);
      prev_row = keypad_row;
      prev_dot = dot_row;
      row_hold = 1;
      mat_hold = 1;
      mat_idx = 0;
      prev_score = 0;
      pair_col = '0;
      pair_shift = 1'b0;
    end else begin
      if (keypad_row != prev_row) begin
        if (row_hold != `PIANO_KEY_PERIOD)
          report_value("keypad_row hold", `PIANO_KEY_PERIOD, row_hold);
        if (keypad_row != {prev_row[2:0], prev_row[3]})
          report_value("keypad_row", {prev_row[2:0], prev_row[3]}, keypad_row);
        prev_row = keypad_row;
        row_hold = 1;
      end else begin
        row_hold++;
        if (row_hold == `PIANO_KEY_PERIOD + 1)
          report_text("keypad_row held longer than its period");
      end
      if (dot_row != prev_dot) begin
        exp_dot = ~(8'h80 >> mat_idx);
        if (mat_hold != `PIANO_ROW_PERIOD)
          report_value("dot_row hold", `PIANO_ROW_PERIOD, mat_hold);
        if (dot_row != exp_dot) report_value("dot_row", exp_dot, dot_row);
        // both rows of a lane agree unless a scroll came between
        if (mat_idx % 2 == 0) begin
          pair_col = dot_col;
          pair_shift = 1'b0;
        end else if (!pair_shift && dot_col != pair_col &&
                     dot_col != (pair_col & ~lane_bits_t'(2'b11))) begin
          report_value("dot_col", pair_col, dot_col);
        end
        mat_idx = (mat_idx + 1) % 8;
        prev_dot = dot_row;
        mat_hold = 1;
      end else begin
        mat_hold++;
        if (mat_hold == `PIANO_ROW_PERIOD + 1)
          report_text("dot_row held longer than its period");
      end
      // lanes shift on the edge after each scroll tick
      if (cycle > 1 && (cycle - 1) % `PIANO_SCROLL_PERIOD == 0) pair_shift = 1'b1;
      if (!runs_ok(dot_col)) report_text("dot_col shows an odd lit run above the bottom");
      tens_d = decode_digit(seg_tens);
      units_d = decode_digit(seg_units);
      score_now = prev_score;
      if (tens_d < 0 || units_d < 0) begin
        report_text("seven-segment pattern is not in the digit table");
      end else begin
        score_now = tens_d * 10 + units_d;
        if (score_now < prev_score || score_now > prev_score + 1)
          report_value("score", prev_score + 1, score_now);
        prev_score = score_now;
      end
      if (cycle < first_start && score_now != 0) report_value("score", 0, score_now);
      if (final_check && score_now != expected_score)
        report_value("final score", expected_score, score_now);
    end
  end

endmodule

// ==== tb/piano_tb.sv ====
`timescale 1ns/1ns
`include "piano_consts.svh"

module piano_tb;
  import piano_pkg::*;

  logic        clk;
  logic        rst;
  logic [3:0]  keypad_col;
  key_row_t    keypad_row;
  mat_row_t    dot_row;
  lane_bits_t  dot_col;
  seg_t        seg_units;
  seg_t        seg_tens;
  logic [69:0] seg_table;
  logic        final_check;
  logic        loaded;
  int          hold_start [`PIANO_LANES];
  int          hold_end [`PIANO_LANES];
  int          expected_score;
  int          first_start;
  int          last_end;
  int          cycle;
  int          tb_errors;
  int          mon_errors;

  piano_top u_piano_top (
    .clk        (clk),
    .rst        (rst),
    .keypad_col (keypad_col),
    .keypad_row (keypad_row),
    .dot_row    (dot_row),
    .dot_col    (dot_col),
    .seg_units  (seg_units),
    .seg_tens   (seg_tens)
  );

  piano_monitor u_monitor (
    .clk            (clk),
    .rst            (rst),
    .keypad_row     (keypad_row),
    .dot_row        (dot_row),
    .dot_col        (dot_col),
    .seg_units      (seg_units),
    .seg_tens       (seg_tens),
    .seg_table      (seg_table),
    .first_start    (first_start),
    .expected_score (expected_score),
    .final_check    (final_check),
    .error_count    (mon_errors)
  );

  always #2 clk = ~clk;

  always @(posedge clk) begin
    if (rst) cycle <= cycle + 1;
  end

  // row bit i low belongs to lane 3-i
  function automatic logic lane_held(input key_row_t row, input int c);
    logic held;
    held = 1'b0;
    for (int i = 0; i < 4; i++) begin
      if (!row[i] && c >= hold_start[3 - i] && c <= hold_end[3 - i] && hold_start[3 - i] >= 0)
        held = 1'b1;
    end
    return held;
  endfunction

  // keypad model, unused columns carry noise
  always @(posedge clk) begin
    #1;
    keypad_col[3:1] = 3'($urandom);
    keypad_col[0] = !lane_held(keypad_row, cycle);
  end

  task automatic read_input;
    int    fd;
    int    n;
    int    a;
    int    b;
    int    c;
    string line;
    string tag;
    fd = $fopen("tb/piano_input.txt", "r");
    if (fd == 0) begin
      tb_errors++;
      $display("cannot open the input file tb/piano_input.txt");
    end else begin
      while (!$feof(fd)) begin
        n = $fgets(line, fd);
        if (n > 0 && line.len() > 0 && line[0] != "#") begin
          if ($sscanf(line, "%s", tag) == 1) begin
            if (tag == "hold" && $sscanf(line, "%s %d %d %d", tag, a, b, c) == 4) begin
              hold_start[a] = b;
              hold_end[a] = c;
            end else if (tag == "score" && $sscanf(line, "%s %d", tag, a) == 2) begin
              expected_score = a;
            end else if (tag == "seg" && $sscanf(line, "%s %d %h", tag, a, b) == 3) begin
              seg_table[a*7 +: 7] = b[6:0];
            end
          end
        end
      end
      $fclose(fd);
    end
  endtask

  initial begin
    clk = 1'b0;
    rst = 1'b0;
    keypad_col = 4'hf;
    final_check = 1'b0;
    loaded = 1'b0;
    cycle = 0;
    tb_errors = 0;
    expected_score = 0;
    seg_table = '1;
    for (int i = 0; i < `PIANO_LANES; i++) begin
      hold_start[i] = -1;
      hold_end[i] = -1;
    end
    void'($urandom(32'h42adf728));
    read_input();
    first_start = 1 << 30;
    last_end = 0;
    for (int i = 0; i < `PIANO_LANES; i++) begin
      if (hold_start[i] >= 0 && hold_start[i] < first_start) first_start = hold_start[i];
      if (hold_end[i] > last_end) last_end = hold_end[i];
    end
    loaded = 1'b1;
    repeat (2) @(posedge clk);
    #1 rst = 1'b1;
    while (cycle < last_end + `PIANO_SCROLL_PERIOD) @(posedge clk);
    #1 final_check = 1'b1;
    @(posedge clk);
    #1 final_check = 1'b0;
    @(negedge clk);
    $display("errors: %0d from monitor, %0d in testbench", mon_errors, tb_errors);
    if (mon_errors == 0 && tb_errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  // watchdog
  initial begin
    wait (loaded);
    repeat (last_end + 4 * `PIANO_SCROLL_PERIOD * `PIANO_DEPTH) @(posedge clk);
    $display("timeout: the run did not reach its end in time");
    $display("Simulation failed");
    $finish;
  end

endmodule

// ==== tb/piano_input.txt ====
# hold <lane> <first cycle> <last cycle>: key of that lane held down
# score <value>: decoded score expected at the end
# seg <digit> <active-low gfedcba pattern in hex>
hold 0 1000 1210
hold 1 1000 1210
hold 2 1000 1210
hold 3 1000 1210
score 2
seg 0 40
seg 1 79
seg 2 24
seg 3 30
seg 4 19
seg 5 12
seg 6 02
seg 7 78
seg 8 00
seg 9 10

// ==== sim.f ====
+incdir+common
common/piano_pkg.sv
rtl/tile_spawner.sv
lane/tile_lane.sv
rtl/keypad_scan.sv
rtl/score_display.sv
rtl/dot_matrix_scan.sv
rtl/piano_top.sv
tb/piano_chk.sv
tb/piano_monitor.sv
tb/piano_tb.sv
